// File: ppu_tx_consts.svh
// ====================
// Widths, register map and range-limit numbers
// for the transmit-clock video back end
// ====================

`ifndef PPU_TX_CONSTS_SVH
`define PPU_TX_CONSTS_SVH

// Pixel path widths
`define PPU_COLOR_W         8
`define PPU_RELPOS_W        8
`define PPU_SL_STR_W        8

// Scanline band is (thickness+1) * 64 positions wide
`define PPU_SL_BAND_SHIFT   6

// Wishbone slave
`define PPU_WB_ADDR_W       2
`define PPU_WB_DATA_W       16

// Register addresses
`define PPU_REG_HSL         2'd0
`define PPU_REG_VSL         2'd1
`define PPU_REG_CTRL        2'd2

// Register field layout
`define PPU_SL_REG_W        7
`define PPU_CTRL_REG_W      2
`define PPU_CTRL_LIMRGB_BIT 0
`define PPU_CTRL_LINK_BIT   1

// Limited RGB range
`define PPU_LIMIT_COEFF     220
`define PPU_LIMIT_OFFSET    16

`endif

// File: ppu_tx_pkg.sv
// ====================
// Types for sync, colour, pixel stream and scanline config
// ====================

`include "ppu_tx_consts.svh"

package ppu_tx_pkg;

  // Sync and data enable, 3 bits
  typedef struct packed {
    logic vsync;
    logic hsync;
    logic de;
  } sync_t;

  // One RGB pixel, 24 bits
  typedef struct packed {
    logic [`PPU_COLOR_W-1:0] red;
    logic [`PPU_COLOR_W-1:0] green;
    logic [`PPU_COLOR_W-1:0] blue;
  } rgb_t;

  // Stream between the scanline stages
  // positions are relative to the current source line and pixel
  typedef struct packed {
    sync_t                    sync;
    rgb_t                     rgb;
    logic [`PPU_RELPOS_W-1:0] hpos_rel;
    logic [`PPU_RELPOS_W-1:0] vpos_rel;
  } pix_t;

  // Final video output
  typedef struct packed {
    sync_t sync;
    rgb_t  rgb;
  } vid_t;

  // Decoded settings of one scanline stage
  typedef struct packed {
    logic                     en;
    logic [1:0]               thickness;
    logic [`PPU_SL_STR_W-1:0] strength;
  } sl_cfg_t;

endpackage

// File: ppu_tx_cfg_regs.sv
// ====================
// Wishbone classic slave with the scanline and range registers
// ====================

`timescale 1ns/1ps
`include "ppu_tx_consts.svh"

module ppu_tx_cfg_regs (
  input  logic                       VCLK_Tx,
  input  logic                       nVRST_Tx,

  // Wishbone classic slave
  input  logic                       wb_cyc_i,
  input  logic                       wb_stb_i,
  input  logic                       wb_we_i,
  input  logic [`PPU_WB_ADDR_W-1:0]  wb_adr_i,
  input  logic [`PPU_WB_DATA_W-1:0]  wb_dat_i,
  output logic [`PPU_WB_DATA_W-1:0]  wb_dat_o,
  output logic                       wb_ack_o,

  // Decoded configuration
  output ppu_tx_pkg::sl_cfg_t        vsl_cfg_o,
  output ppu_tx_pkg::sl_cfg_t        hsl_cfg_o,
  output logic                       limited_rgb_o
);

  logic [`PPU_SL_REG_W-1:0]   hsl_q;
  logic [`PPU_SL_REG_W-1:0]   vsl_q;
  logic [`PPU_CTRL_REG_W-1:0] ctrl_q;
  logic                       wb_req;
  logic [`PPU_SL_REG_W-1:0]   vsl_src;

  // Register to config: en bit 0, thickness 2:1, strength code 6:3
  // strength (s+1)*16-1 is just the code with four ones appended
  function automatic ppu_tx_pkg::sl_cfg_t decode_sl(
    input logic [`PPU_SL_REG_W-1:0] r
  );
    ppu_tx_pkg::sl_cfg_t c;
    c.en        = r[0];
    c.thickness = r[2:1];
    c.strength  = {r[6:3], 4'hf};
    return c;
  endfunction

  // ====================
  // Wishbone handshake
  // ====================

  // One request per ack, no wait states
  assign wb_req = wb_cyc_i & wb_stb_i & ~wb_ack_o;

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      wb_ack_o <= 1'b0;
      hsl_q    <= '0;
      vsl_q    <= '0;
      ctrl_q   <= '0;
    end else begin
      wb_ack_o <= wb_req;
      if (wb_req && wb_we_i) begin
        case (wb_adr_i)
          `PPU_REG_HSL:  hsl_q  <= wb_dat_i[`PPU_SL_REG_W-1:0];
          `PPU_REG_VSL:  vsl_q  <= wb_dat_i[`PPU_SL_REG_W-1:0];
          `PPU_REG_CTRL: ctrl_q <= wb_dat_i[`PPU_CTRL_REG_W-1:0];
          default: ;
        endcase
      end
    end
  end

  // Read back, address is held by the master until ack
  always_comb begin
    wb_dat_o = '0;
    case (wb_adr_i)
      `PPU_REG_HSL:  wb_dat_o[`PPU_SL_REG_W-1:0]   = hsl_q;
      `PPU_REG_VSL:  wb_dat_o[`PPU_SL_REG_W-1:0]   = vsl_q;
      `PPU_REG_CTRL: wb_dat_o[`PPU_CTRL_REG_W-1:0] = ctrl_q;
      default: ;
    endcase
  end

  // ====================
  // Config decode
  // ====================

  // Linked mode takes thickness and strength from HSL
  // vertical enable stays with VSL
  assign vsl_src = ctrl_q[`PPU_CTRL_LINK_BIT] ? {hsl_q[6:1], vsl_q[0]} : vsl_q;

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      hsl_cfg_o     <= '0;
      vsl_cfg_o     <= '0;
      limited_rgb_o <= 1'b0;
    end else begin
      hsl_cfg_o     <= decode_sl(hsl_q);
      vsl_cfg_o     <= decode_sl(vsl_src);
      limited_rgb_o <= ctrl_q[`PPU_CTRL_LIMRGB_BIT];
    end
  end

endmodule

// File: scanline_emu.sv
// ====================
// Scanline stage that dims pixels inside the band
// ====================

`timescale 1ns/1ps
`include "ppu_tx_consts.svh"

module scanline_emu #(
  // Set to compare vpos_rel, clear to compare hpos_rel
  parameter bit SEL_VPOS = 1'b0
) (
  input  logic                VCLK_Tx,
  input  logic                nVRST_Tx,
  input  ppu_tx_pkg::pix_t    pix_i,
  input  ppu_tx_pkg::sl_cfg_t sl_cfg_i,
  output ppu_tx_pkg::pix_t    pix_o
);

  logic [`PPU_RELPOS_W-1:0] rel_pos;
  logic [`PPU_RELPOS_W:0]   band_end;
  logic                     in_band;
  ppu_tx_pkg::rgb_t         rgb_dim;

  ppu_tx_pkg::sync_t        sync_q;
  ppu_tx_pkg::rgb_t         rgb_q;
  logic [`PPU_RELPOS_W-1:0] hpos_q;
  logic [`PPU_RELPOS_W-1:0] vpos_q;

  // c - floor(c*strength/256)
  function automatic logic [`PPU_COLOR_W-1:0] dim_chan(
    input logic [`PPU_COLOR_W-1:0]  c,
    input logic [`PPU_SL_STR_W-1:0] str
  );
    logic [`PPU_COLOR_W+`PPU_SL_STR_W-1:0] prod;
    prod = (`PPU_COLOR_W+`PPU_SL_STR_W)'(c) * (`PPU_COLOR_W+`PPU_SL_STR_W)'(str);
    return c - prod[`PPU_COLOR_W+`PPU_SL_STR_W-1 -: `PPU_COLOR_W];
  endfunction

  assign rel_pos = SEL_VPOS ? pix_i.vpos_rel : pix_i.hpos_rel;

  // Band ends at (thickness+1)*64 and the extra bit holds 256
  assign band_end = (`PPU_RELPOS_W+1)'(sl_cfg_i.thickness + 3'd1) << `PPU_SL_BAND_SHIFT;

  assign in_band = sl_cfg_i.en & pix_i.sync.de & ({1'b0, rel_pos} < band_end);

  always_comb begin
    rgb_dim.red   = dim_chan(pix_i.rgb.red,   sl_cfg_i.strength);
    rgb_dim.green = dim_chan(pix_i.rgb.green, sl_cfg_i.strength);
    rgb_dim.blue  = dim_chan(pix_i.rgb.blue,  sl_cfg_i.strength);
  end

  // ====================
  // Output register
  // ====================

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      sync_q <= '0;
    end else begin
      sync_q <= pix_i.sync;
    end
  end

  // Colour and positions travel with the sync
  always_ff @(posedge VCLK_Tx) begin
    rgb_q  <= in_band ? rgb_dim : pix_i.rgb;
    hpos_q <= pix_i.hpos_rel;
    vpos_q <= pix_i.vpos_rel;
  end

  assign pix_o = {sync_q, rgb_q, hpos_q, vpos_q};

endmodule

// File: rgb_range_limit.sv
// ====================
// Output register stages with optional limited RGB range
// ====================

`timescale 1ns/1ps
`include "ppu_tx_consts.svh"

module rgb_range_limit (
  input  logic             VCLK_Tx,
  input  logic             nVRST_Tx,
  input  ppu_tx_pkg::vid_t vid_i,
  input  logic             limited_rgb_i,
  output ppu_tx_pkg::vid_t vid_o
);

  logic [`PPU_COLOR_W-1:0]   chan_in [3];
  logic [2*`PPU_COLOR_W-1:0] prod    [3];
  logic [`PPU_COLOR_W:0]     s1_lim  [3];
  logic [`PPU_COLOR_W-1:0]   s2_lim  [3];
  logic [`PPU_COLOR_W-1:0]   s3_lim  [3];
  ppu_tx_pkg::rgb_t          s1_full;
  ppu_tx_pkg::rgb_t          s2_full;
  ppu_tx_pkg::rgb_t          s3_rgb;
  ppu_tx_pkg::sync_t         s1_sync;
  ppu_tx_pkg::sync_t         s2_sync;

  assign chan_in[0] = vid_i.rgb.red;
  assign chan_in[1] = vid_i.rgb.green;
  assign chan_in[2] = vid_i.rgb.blue;

  // Scale by 220/256 and add the black level
  always_comb begin
    for (int ch = 0; ch < 3; ch++) begin
      prod[ch]   = (2*`PPU_COLOR_W)'(chan_in[ch]) * (2*`PPU_COLOR_W)'(`PPU_LIMIT_COEFF);
      s3_lim[ch] = s2_lim[ch] + `PPU_COLOR_W'(`PPU_LIMIT_OFFSET);
    end
  end

  assign s3_rgb = limited_rgb_i ? {s3_lim[0], s3_lim[1], s3_lim[2]} : s2_full;

  // ====================
  // Pipeline
  // ====================

  // Stage 1 keeps the top 9 product bits, stage 2 rounds to 8
  always_ff @(posedge VCLK_Tx) begin
    for (int ch = 0; ch < 3; ch++) begin
      s1_lim[ch] <= prod[ch][2*`PPU_COLOR_W-1 -: `PPU_COLOR_W+1];
      s2_lim[ch] <= s1_lim[ch][`PPU_COLOR_W:1] + `PPU_COLOR_W'(s1_lim[ch][0]);
    end
    s1_full <= vid_i.rgb;
    s2_full <= s1_full;
  end

  // Sync follows the colour pipeline
  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      s1_sync <= '0;
      s2_sync <= '0;
      vid_o   <= '0;
    end else begin
      s1_sync <= vid_i.sync;
      s2_sync <= s1_sync;
      vid_o   <= {s2_sync, s3_rgb};
    end
  end

endmodule

// File: ppu_tx_top.sv
// ====================
// Transmit-side top: config slave, two scanline stages, output stage
// ====================

`timescale 1ns/1ps
`include "ppu_tx_consts.svh"

module ppu_tx_top (
  input  logic                      VCLK_Tx,
  input  logic                      nVRST_Tx,

  // Wishbone classic slave
  input  logic                      wb_cyc_i,
  input  logic                      wb_stb_i,
  input  logic                      wb_we_i,
  input  logic [`PPU_WB_ADDR_W-1:0] wb_adr_i,
  input  logic [`PPU_WB_DATA_W-1:0] wb_dat_i,
  output logic [`PPU_WB_DATA_W-1:0] wb_dat_o,
  output logic                      wb_ack_o,

  // Video
  input  ppu_tx_pkg::pix_t          pix_i,
  output ppu_tx_pkg::vid_t          vid_o
);

  ppu_tx_pkg::sl_cfg_t vsl_cfg;
  ppu_tx_pkg::sl_cfg_t hsl_cfg;
  logic                limited_rgb;
  ppu_tx_pkg::pix_t    vsl_pix;
  ppu_tx_pkg::pix_t    hsl_pix;
  ppu_tx_pkg::vid_t    hsl_vid;

  ppu_tx_cfg_regs u_cfg_regs (
    .VCLK_Tx       (VCLK_Tx),
    .nVRST_Tx      (nVRST_Tx),
    .wb_cyc_i      (wb_cyc_i),
    .wb_stb_i      (wb_stb_i),
    .wb_we_i       (wb_we_i),
    .wb_adr_i      (wb_adr_i),
    .wb_dat_i      (wb_dat_i),
    .wb_dat_o      (wb_dat_o),
    .wb_ack_o      (wb_ack_o),
    .vsl_cfg_o     (vsl_cfg),
    .hsl_cfg_o     (hsl_cfg),
    .limited_rgb_o (limited_rgb)
  );

  // Vertical scanlines run along hpos
  scanline_emu #(.SEL_VPOS(1'b0)) u_vsl (
    .VCLK_Tx  (VCLK_Tx),
    .nVRST_Tx (nVRST_Tx),
    .pix_i    (pix_i),
    .sl_cfg_i (vsl_cfg),
    .pix_o    (vsl_pix)
  );

  scanline_emu #(.SEL_VPOS(1'b1)) u_hsl (
    .VCLK_Tx  (VCLK_Tx),
    .nVRST_Tx (nVRST_Tx),
    .pix_i    (vsl_pix),
    .sl_cfg_i (hsl_cfg),
    .pix_o    (hsl_pix)
  );

  // Positions end at the last scanline stage
  assign hsl_vid = {hsl_pix.sync, hsl_pix.rgb};

  rgb_range_limit u_range_limit (
    .VCLK_Tx       (VCLK_Tx),
    .nVRST_Tx      (nVRST_Tx),
    .vid_i         (hsl_vid),
    .limited_rgb_i (limited_rgb),
    .vid_o         (vid_o)
  );

endmodule

// File: tb_clk_gen.sv
// ====================
// Testbench clock and reset
// ====================

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS  = 4,
  parameter int RST_CYCLES = 2
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
  end

  // Release reset just after a rising edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #1;
    rst_n_o = 1'b1;
  end

endmodule

// File: tb_ppu_tx_top.sv
// ====================
// Testbench for ppu_tx_top driven by records from ppu_tx_input.txt
// ====================

`timescale 1ns/1ps
`include "ppu_tx_consts.svh"

module tb_ppu_tx_top;

  localparam int LATENCY  = 5;
  localparam int ACK_WAIT = 8;

  typedef struct packed {
    logic [7:0]  kind;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] d;
    logic [31:0] e;
  } rec_t;

  logic                      VCLK_Tx;
  logic                      nVRST_Tx;
  logic                      wb_cyc;
  logic                      wb_stb;
  logic                      wb_we;
  logic [`PPU_WB_ADDR_W-1:0] wb_adr;
  logic [`PPU_WB_DATA_W-1:0] wb_dat_w;
  logic [`PPU_WB_DATA_W-1:0] wb_dat_r;
  logic                      wb_ack;
  ppu_tx_pkg::pix_t          pix;
  ppu_tx_pkg::vid_t          vid;

  rec_t        recs [$];
  logic [31:0] exp_q [$];
  logic [6:0]  hsl_sh;
  logic [6:0]  vsl_sh;
  logic [1:0]  ctrl_sh;
  bit          pix_sent;
  int          wd_limit;
  int          errors;
  int          test_err;
  int          test_checks;
  int          cur_test;
  int          tests_run;
  int          tests_failed;
  string       test_names [1:6] = '{"reset", "regs", "bypass", "vsl", "link", "limited"};

  tb_clk_gen #(.PERIOD_NS(4), .RST_CYCLES(2)) u_clk_gen (
    .clk_o   (VCLK_Tx),
    .rst_n_o (nVRST_Tx)
  );

  ppu_tx_top u_dut (
    .VCLK_Tx  (VCLK_Tx),
    .nVRST_Tx (nVRST_Tx),
    .wb_cyc_i (wb_cyc),
    .wb_stb_i (wb_stb),
    .wb_we_i  (wb_we),
    .wb_adr_i (wb_adr),
    .wb_dat_i (wb_dat_w),
    .wb_dat_o (wb_dat_r),
    .wb_ack_o (wb_ack),
    .pix_i    (pix),
    .vid_o    (vid)
  );

  // ====================
  // Reference model
  // ====================

  function automatic logic [7:0] dimmed_chan(input logic [7:0] c, input logic [7:0] s);
    return c - 8'((16'(c) * 16'(s)) / 256);
  endfunction

  function automatic logic [7:0] limited_chan(input logic [7:0] c);
    return 8'((32'(c) * 220 / 128 + 1) / 2 + 16);
  endfunction

  // Strength code s gives (s+1)*16-1 and the band ends at (thickness+1)*64
  function automatic ppu_tx_pkg::rgb_t scan_expect(input ppu_tx_pkg::rgb_t c,
      input logic [6:0] r, input bit en, input bit de, input logic [7:0] pos);
    int               str;
    ppu_tx_pkg::rgb_t o;
    str = (int'(r[6:3]) + 1) * 16 - 1;
    o = c;
    if (en && de && int'(pos) < (int'(r[2:1]) + 1) * 64) begin
      o.red   = dimmed_chan(c.red, 8'(str));
      o.green = dimmed_chan(c.green, 8'(str));
      o.blue  = dimmed_chan(c.blue, 8'(str));
    end
    return o;
  endfunction

  // Link borrows HSL thickness and strength while enable stays with VSL
  function automatic logic [26:0] model_vid(input ppu_tx_pkg::pix_t p);
    ppu_tx_pkg::rgb_t c;
    c = scan_expect(p.rgb, ctrl_sh[1] ? hsl_sh : vsl_sh, vsl_sh[0], p.sync.de, p.hpos_rel);
    c = scan_expect(c, hsl_sh, hsl_sh[0], p.sync.de, p.vpos_rel);
    if (ctrl_sh[0]) begin
      c.red   = limited_chan(c.red);
      c.green = limited_chan(c.green);
      c.blue  = limited_chan(c.blue);
    end
    return {p.sync, c};
  endfunction

  // ====================
  // Drivers and checks
  // ====================

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    test_checks++;
    if (got !== exp) begin
      $display("[FAIL] %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      errors++;
      test_err++;
    end
  endtask

  // One clock with the output checked against the pixel sent LATENCY clocks before
  task automatic step_cycle(input ppu_tx_pkg::pix_t p, input bit chk, input logic [26:0] expv);
    logic [31:0] slot;
    @(posedge VCLK_Tx);
    #1;
    if (exp_q.size() == LATENCY) begin
      slot = exp_q.pop_front();
      if (slot[31]) check_value("vid_o", 32'(vid), {5'b0, slot[26:0]});
    end
    pix = p;
    exp_q.push_back({chk, 4'b0, expv});
  endtask

  task automatic idle_cycle();
    step_cycle('0, 1'b0, '0);
  endtask

  task automatic drain_pipe();
    if (pix_sent) begin
      repeat (LATENCY) idle_cycle();
      pix_sent = 1'b0;
    end
  endtask

  task automatic send_pixel(input ppu_tx_pkg::pix_t p, input logic [26:0] expv);
    pix_sent = 1'b1;
    step_cycle(p, 1'b1, expv);
  endtask

  task automatic wb_access(input bit we, input logic [1:0] adr, input logic [15:0] wdat,
                           output logic [15:0] rdat);
    int waited;
    drain_pipe();
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdat;
    waited   = 0;
    // Ack must not rise before the next clock edge
    #1;
    check_value("wb_ack_o", 32'(wb_ack), 32'd0);
    do begin
      idle_cycle();
      waited++;
    end while (!wb_ack && waited < ACK_WAIT);
    if (!wb_ack) begin
      $display("No Wishbone ack within %0d cycles at address %0d", ACK_WAIT, adr);
      errors++;
      test_err++;
    end else begin
      check_value("wb_ack_o delay", 32'(waited), 32'd1);
    end
    rdat   = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    // New config reaches the first stage one clock after ack
    idle_cycle();
  endtask

  task automatic close_test();
    drain_pipe();
    if (cur_test != 0) begin
      tests_run++;
      if (test_err != 0) tests_failed++;
      $display("Test %0d %-8s %0d checks, %0d errors", cur_test, test_names[cur_test],
               test_checks, test_err);
    end
    test_err    = 0;
    test_checks = 0;
  endtask

  task automatic load_records(output bit ok, output int rnd_total);
    int          fd;
    string       line;
    logic [7:0]  kind;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] d;
    logic [31:0] e;
    rnd_total = 0;
    fd = $fopen("ppu_tx_input.txt", "r");
    ok = (fd != 0);
    while (ok && !$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 1 && line[0] != "#") begin
        {a, b, c, d, e} = '0;
        void'($sscanf(line, "%c %h %h %h %h %h", kind, a, b, c, d, e));
        recs.push_back({kind, a, b, c, d, e});
        if (kind == "X") rnd_total += a;
      end
    end
    if (ok) $fclose(fd);
  endtask

  task automatic run_records();
    rec_t             r;
    logic [15:0]      rd;
    ppu_tx_pkg::pix_t p;
    foreach (recs[i]) begin
      r = recs[i];
      case (r.kind)
        "T": begin
          close_test();
          cur_test = int'(r.a);
          if (cur_test == 1) begin
            check_value("vid_o", 32'(vid), 32'd0);
            check_value("wb_ack_o", 32'(wb_ack), 32'd0);
          end
        end
        "W": begin
          wb_access(1'b1, r.a[1:0], r.b[15:0], rd);
          if (r.a[1:0] == `PPU_REG_HSL) hsl_sh = r.b[6:0];
          else if (r.a[1:0] == `PPU_REG_VSL) vsl_sh = r.b[6:0];
          else if (r.a[1:0] == `PPU_REG_CTRL) ctrl_sh = r.b[1:0];
        end
        "R": begin
          wb_access(1'b0, r.a[1:0], 16'h0, rd);
          check_value("wb_dat_o", 32'(rd), r.b);
        end
        "P": send_pixel({r.a[2:0], r.b[23:0], r.c[7:0], r.d[7:0]}, r.e[26:0]);
        "X": begin
          repeat (r.a) begin
            p.sync     = 3'($urandom());
            p.rgb      = 24'($urandom());
            p.hpos_rel = 8'($urandom());
            p.vpos_rel = 8'($urandom());
            send_pixel(p, model_vid(p));
          end
        end
        default: begin
          $display("Unknown record kind in stimulus file at record %0d", i);
          errors++;
        end
      endcase
    end
    close_test();
  endtask

  // ====================
  // Main sequence and watchdog
  // ====================

  initial begin
    bit ok;
    int rnd_total;
    void'($urandom(58));
    {wb_cyc, wb_stb, wb_we} = '0;
    wb_adr   = '0;
    wb_dat_w = '0;
    pix      = '0;
    {hsl_sh, vsl_sh, ctrl_sh} = '0;
    load_records(ok, rnd_total);
    if (ok) begin
      wd_limit = (recs.size() + rnd_total + 20) * 4 * 4;
      wait (nVRST_Tx === 1'b1);
      run_records();
    end else begin
      $display("Could not open stimulus file ppu_tx_input.txt");
      errors++;
    end
    $display("Summary: %0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin
    wait (wd_limit > 0);
    #(wd_limit);
    $display("Timeout, run stopped at %0t while in test %0d", $time, cur_test);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// File: ppu_tx_input.txt
# T test | W adr data | R adr expect | P sync rgb hpos vpos expect_vid | X random_count
# All values hex, sync is {vsync,hsync,de} and expect_vid is {sync,r,g,b}
T 1
R 0 0
R 1 0
R 2 0
T 2
W 0 ffff
R 0 7f
W 1 0055
R 1 55
W 2 fffe
R 2 2
T 3
W 0 0
W 1 0
W 2 0
P 1 123456 10 10 1123456
P 7 abcdef 00 00 7abcdef
P 0 ffffff 20 30 0ffffff
T 4
W 1 39
P 1 80ff10 10 00 1418109
P 1 80ff10 40 00 180ff10
P 0 80ff10 10 00 080ff10
W 1 3b
P 5 80ff10 7f 33 5418109
P 1 80ff10 80 33 180ff10
W 1 3d
P 1 80ff10 bf 00 1418109
P 1 80ff10 c0 00 180ff10
W 1 7f
P 3 ff4001 ff 00 3010101
P 6 ff4001 00 00 6ff4001
T 5
W 2 2
P 1 c8c8c8 10 00 1bdbdbd
P 1 c8c8c8 80 00 1c8c8c8
W 0 1
P 1 c8c8c8 10 10 1b2b2b2
P 1 c8c8c8 10 80 1bdbdbd
W 0 39
P 1 808080 00 00 1212121
T 6
W 0 0
W 1 0
W 2 1
P 7 00ff80 00 00 710eb7e
P 0 ff0000 00 00 0eb1010
X 18

// File: ppu_tx_top.f
+incdir+.
ppu_tx_pkg.sv
ppu_tx_cfg_regs.sv
scanline_emu.sv
rgb_range_limit.sv
ppu_tx_top.sv
tb_clk_gen.sv
tb_ppu_tx_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the ppu_tx_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_ppu_tx_top -f ppu_tx_top.f -o sim_ppu_tx
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_ppu_tx)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "ALL TESTS PASSED"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
